// File: Bender.yml
package:
  name: fifo_dc

sources:
  # design, in compile order
  - logic/fifo_pkg.sv
  - logic/ram_if.sv
  - logic/ram_tp.sv
  - logic/ptr_sync.sv
  - logic/fifo_dc.sv

  # simulation only
  - target: test
    files:
      - bench/fifo_dc_assert.sv
      - bench/fifo_dc_tb.sv

// File: bench/fifo_dc_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-clock fifo checker: status flags against the
// level counts, and read data hold between reads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fifo_dc_assert import fifo_pkg::*; (
    input logic   wr_clk_i,
    input logic   wr_rst_n_i,
    input logic   wr_last_i,
    input logic   wr_full_i,
    input level_t wr_free_i,

    input logic   rd_clk_i,
    input logic   rd_rst_n_i,
    input logic   rd_en_i,
    input data_t  rd_data_i,
    input logic   rd_last_i,
    input logic   rd_empty_i,
    input level_t rd_avail_i
);

    int fail_cnt = 0; // summed into the testbench error count.

    // write side flags agree with the free count.
    a_full_free: assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
        wr_full_i |-> wr_free_i == '0)
        else begin
            $error("wr_full_o is set while wr_free_o is %0d", wr_free_i);
            fail_cnt++;
        end

    a_last_free: assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
        wr_last_i |-> wr_free_i == level_t'(1))
        else begin
            $error("wr_last_o is set while wr_free_o is %0d", wr_free_i);
            fail_cnt++;
        end

    a_free_max: assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
        wr_free_i <= level_t'(FIFO_DEPTH))
        else begin
            $error("wr_free_o is %0d, above the fifo depth", wr_free_i);
            fail_cnt++;
        end

    // read side flags agree with the available count.
    a_empty_avail: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        rd_empty_i |-> rd_avail_i == '0)
        else begin
            $error("rd_empty_o is set while rd_avail_o is %0d", rd_avail_i);
            fail_cnt++;
        end

    a_last_avail: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        rd_last_i |-> rd_avail_i == level_t'(1))
        else begin
            $error("rd_last_o is set while rd_avail_o is %0d", rd_avail_i);
            fail_cnt++;
        end

    a_avail_max: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        rd_avail_i <= level_t'(FIFO_DEPTH))
        else begin
            $error("rd_avail_o is %0d, above the fifo depth", rd_avail_i);
            fail_cnt++;
        end

    // an edge without an accepted read must leave the output register alone.
    a_data_hold: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        !(rd_en_i && !rd_empty_i) |=> rd_data_i === $past(rd_data_i))
        else begin
            $error("rd_data_o changed without an accepted read");
            fail_cnt++;
        end

endmodule

bind fifo_dc fifo_dc_assert u_assert (
    .wr_clk_i   (wr_clk_i),
    .wr_rst_n_i (wr_rst_n_i),
    .wr_last_i  (wr_last_o),
    .wr_full_i  (wr_full_o),
    .wr_free_i  (wr_free_o),
    .rd_clk_i   (rd_clk_i),
    .rd_rst_n_i (rd_rst_n_i),
    .rd_en_i    (rd_en_i),
    .rd_data_i  (rd_data_o),
    .rd_last_i  (rd_last_o),
    .rd_empty_i (rd_empty_o),
    .rd_avail_i (rd_avail_o)
);

// File: bench/fifo_dc_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the dual-clock fifo that runs fill,
// drain and random traffic against a reference queue.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fifo_dc_tb import fifo_pkg::*; ();

    localparam logic [31:0] SEED    = 32'h61c0_fde6;
    localparam int          TIMEOUT = 400;

    logic   wr_clk   = 1'b0;
    logic   rd_clk   = 1'b0;
    logic   wr_rst_n = 1'b0;
    logic   rd_rst_n = 1'b0;
    logic   wr_en    = 1'b0;
    data_t  wr_data  = '0;
    logic   rd_en    = 1'b0;
    logic   wr_last;
    logic   wr_full;
    level_t wr_free;
    data_t  rd_data;
    logic   rd_last;
    logic   rd_empty;
    level_t rd_avail;

    data_t       ref_q [$]; // words accepted but not yet read.
    data_t       rd_expect;
    logic        rd_pending   = 1'b0;
    logic [31:0] rng_q        = SEED;
    int          error_cnt    = 0;
    int          wr_accepted  = 0;
    int          rd_accepted  = 0;
    logic        wr_last_seen = 1'b0;
    logic        rd_last_seen = 1'b0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    always #7 wr_clk = ~wr_clk;  // 14 ns period that drifts against the reader.
    always #10 rd_clk = ~rd_clk; // 20 ns period.

    fifo_dc u_dut (
        .wr_clk_i   (wr_clk),
        .wr_rst_n_i (wr_rst_n),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .wr_last_o  (wr_last),
        .wr_full_o  (wr_full),
        .wr_free_o  (wr_free),
        .rd_clk_i   (rd_clk),
        .rd_rst_n_i (rd_rst_n),
        .rd_en_i    (rd_en),
        .rd_data_o  (rd_data),
        .rd_last_o  (rd_last),
        .rd_empty_o (rd_empty),
        .rd_avail_o (rd_avail)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_errors();
        return error_cnt + u_dut.u_assert.fail_cnt;
    endfunction

    task automatic value_error(input string msg);
        $display("[ERROR] %t: %s", $time, msg);
        error_cnt++;
    endtask

    task automatic timeout_error(input string what);
        $display("timeout: gave up waiting for %s", what);
        error_cnt++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failures", name, total_errors() - errs_before);
        end
    endtask

    // both enables are low here, so the pointers settle in both domains.
    task automatic check_idle_levels(input string when_str);
        repeat (5) @(posedge wr_clk);
        repeat (5) @(posedge rd_clk);
        @(negedge rd_clk);
        assert (int'(wr_free) + int'(rd_avail) == FIFO_DEPTH) else
            value_error($sformatf("%s: free %0d plus avail %0d is not the depth",
                                  when_str, wr_free, rd_avail));
    endtask

    // write side status is settled at the falling edge for the next rising one.
    always @(negedge wr_clk) begin
        if (wr_rst_n && wr_en && !wr_full) begin
            ref_q.push_back(wr_data);
            wr_accepted++;
        end
        if (wr_last) begin
            wr_last_seen = 1'b1;
        end
    end

    // a read accepted at a rising edge is checked at the falling edge after it.
    always @(negedge rd_clk) begin
        if (rd_pending) begin
            assert (rd_data === rd_expect) else
                value_error($sformatf("read data %h, expected %h", rd_data, rd_expect));
        end
        rd_pending = 1'b0;
        if (rd_rst_n && rd_en && !rd_empty) begin
            rd_accepted++;
            if (ref_q.size() == 0) begin
                value_error("read accepted with no word in the reference queue");
            end else begin
                rd_expect  = ref_q.pop_front();
                rd_pending = 1'b1;
            end
        end
        if (rd_last) begin
            rd_last_seen = 1'b1;
        end
    end

    initial begin
        int    errs;
        int    guard;
        int    wr_start;
        int    rd_start;
        data_t held;

        $timeformat(-9, 0, " ns", 0);
        fork
            begin
                repeat (2) @(posedge wr_clk);
                wr_rst_n <= 1'b1;
            end
            begin
                repeat (2) @(posedge rd_clk);
                rd_rst_n <= 1'b1;
            end
        join

        errs = total_errors();
        @(negedge rd_clk);
        assert (rd_empty && !rd_last && rd_avail == '0) else
            value_error("read side status differs from its reset value");
        assert (!wr_full && !wr_last && wr_free == level_t'(FIFO_DEPTH)) else
            value_error("write side status differs from its reset value");
        finish_test("reset", errs);

        errs = total_errors();
        wr_last_seen = 1'b0;
        wr_start = wr_accepted;
        guard = 0;
        @(posedge wr_clk);
        while (wr_accepted - wr_start < FIFO_DEPTH && guard < TIMEOUT) begin
            wr_en   <= 1'b1;
            wr_data <= data_t'(8'ha0 + guard);
            @(posedge wr_clk);
            guard++;
        end
        wr_en <= 1'b0;
        if (guard >= TIMEOUT) begin
            timeout_error("the writes that fill the FIFO");
        end
        guard = 0;
        @(negedge wr_clk);
        while (wr_free != '0 && guard < TIMEOUT) begin
            @(negedge wr_clk);
            guard++;
        end
        if (guard >= TIMEOUT) begin
            timeout_error("wr_free_o to reach zero");
        end
        assert (wr_full) else value_error("wr_full_o low with no free slot");
        assert (wr_last_seen) else value_error("wr_last_o never seen during fill");
        // these words must never come out.
        repeat (3) begin
            @(posedge wr_clk);
            wr_en   <= 1'b1;
            wr_data <= 8'hee;
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
        check_idle_levels("after fill");
        finish_test("fill", errs);

        errs = total_errors();
        rd_last_seen = 1'b0;
        rd_start = rd_accepted;
        @(posedge rd_clk);
        rd_en <= 1'b1;
        guard = 0;
        @(negedge rd_clk);
        while (!rd_empty && guard < TIMEOUT) begin
            @(negedge rd_clk);
            guard++;
        end
        if (guard >= TIMEOUT) begin
            timeout_error("rd_empty_o during drain");
        end
        held = rd_data;
        repeat (4) begin
            @(negedge rd_clk);
            assert (rd_data === held) else
                value_error($sformatf("read while empty changed data to %h", rd_data));
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
        assert (rd_accepted - rd_start == FIFO_DEPTH) else
            value_error($sformatf("drain gave %0d words", rd_accepted - rd_start));
        assert (rd_last_seen) else value_error("rd_last_o never seen during drain");
        assert (ref_q.size() == 0) else value_error("reference queue not empty after drain");
        check_idle_levels("after drain");
        finish_test("drain", errs);

        errs = total_errors();
        wr_start = wr_accepted;
        rd_start = rd_accepted;
        // the two clocks never share a rising edge, so one generator serves both.
        fork
            begin
                repeat (400) begin
                    @(posedge wr_clk);
                    rng_q = lcg_next(rng_q);
                    wr_en   <= (rng_q[31:28] < 4'd7);
                    wr_data <= rng_q[23:16];
                end
                @(posedge wr_clk);
                wr_en <= 1'b0;
            end
            begin
                repeat (280) begin
                    @(posedge rd_clk);
                    rng_q = lcg_next(rng_q);
                    rd_en <= (rng_q[31:28] < 4'd10);
                end
            end
        join
        @(posedge rd_clk);
        rd_en <= 1'b1;
        guard = 0;
        @(negedge rd_clk);
        while (!(rd_empty && ref_q.size() == 0) && guard < TIMEOUT) begin
            @(negedge rd_clk);
            guard++;
        end
        if (guard >= TIMEOUT) begin
            timeout_error("the final drain after random traffic");
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
        check_idle_levels("after random traffic");
        assert (wr_accepted - wr_start == rd_accepted - rd_start) else
            value_error($sformatf("%0d words written but %0d read",
                                  wr_accepted - wr_start, rd_accepted - rd_start));
        finish_test("traffic", errs);

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/fifo_pkg.sv
logic/ram_if.sv
logic/ram_tp.sv
logic/ptr_sync.sv
logic/fifo_dc.sv
bench/fifo_dc_assert.sv
bench/fifo_dc_tb.sv

// File: logic/fifo_dc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-clock fifo top: pointers, status, level counts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fifo_dc import fifo_pkg::*; (
    input  logic   wr_clk_i,
    input  logic   wr_rst_n_i,

    input  logic   wr_en_i,
    input  data_t  wr_data_i,
    output logic   wr_last_o,
    output logic   wr_full_o,
    output level_t wr_free_o,

    input  logic   rd_clk_i,
    input  logic   rd_rst_n_i,

    input  logic   rd_en_i,
    output data_t  rd_data_o,
    output logic   rd_last_o,
    output logic   rd_empty_o,
    output level_t rd_avail_o
);

    // write domain.
    ptr_t   wr_ptr_q;
    ptr_t   wr_ptr_next;
    ptr_t   rd_ptr_wr; // read pointer as seen by the writer.
    level_t wr_used;
    logic   wr_accept;

    // read domain.
    ptr_t   rd_ptr_q;
    ptr_t   rd_ptr_next;
    ptr_t   wr_ptr_rd; // write pointer as seen by the reader.
    logic   rd_accept;

    ram_if u_ram_if ();

    assign wr_ptr_next = wr_ptr_q + 1'b1;
    assign rd_ptr_next = rd_ptr_q + 1'b1;

    assign wr_accept = wr_en_i & ~wr_full_o;
    assign rd_accept = rd_en_i & ~rd_empty_o;

    // the synced read pointer lags the real one, so the writer can only
    // see the fifo fuller than it is.
    assign wr_full_o = (wr_ptr_q[ADDR_W-1:0] == rd_ptr_wr[ADDR_W-1:0]) &&
                       (wr_ptr_q[ADDR_W] != rd_ptr_wr[ADDR_W]);
    assign wr_last_o = (wr_ptr_next[ADDR_W-1:0] == rd_ptr_wr[ADDR_W-1:0]) &&
                       (wr_ptr_next[ADDR_W] != rd_ptr_wr[ADDR_W]);

    assign wr_used   = wr_ptr_q - rd_ptr_wr; // wraps correctly with the extra bit.
    assign wr_free_o = level_t'(FIFO_DEPTH) - wr_used;

    // likewise the reader can only see the fifo emptier than it is.
    assign rd_empty_o = (wr_ptr_rd == rd_ptr_q);
    assign rd_last_o  = (wr_ptr_rd == rd_ptr_next);
    assign rd_avail_o = wr_ptr_rd - rd_ptr_q;

    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_ptr_q <= '0;
        end else if (wr_accept) begin
            wr_ptr_q <= wr_ptr_next;
        end
    end

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (rd_accept) begin
            rd_ptr_q <= rd_ptr_next;
        end
    end

    // memory ports, strobed only for accepted operations so that
    // rejected ones touch neither the storage nor the read register.
    assign u_ram_if.wr_en   = wr_accept;
    assign u_ram_if.wr_addr = wr_ptr_q[ADDR_W-1:0];
    assign u_ram_if.wr_data = wr_data_i;
    assign u_ram_if.rd_en   = rd_accept;
    assign u_ram_if.rd_addr = rd_ptr_q[ADDR_W-1:0];

    assign rd_data_o = u_ram_if.rd_data;

    ram_tp u_ram (
        .wr_clk_i (wr_clk_i),
        .rd_clk_i (rd_clk_i),
        .ram      (u_ram_if.mem)
    );

    // write pointer into the read domain.
    ptr_sync u_wr2rd (
        .src_clk_i   (wr_clk_i),
        .src_rst_n_i (wr_rst_n_i),
        .src_ptr_i   (wr_ptr_q),
        .dst_clk_i   (rd_clk_i),
        .dst_rst_n_i (rd_rst_n_i),
        .dst_ptr_o   (wr_ptr_rd)
    );

    // read pointer into the write domain.
    ptr_sync u_rd2wr (
        .src_clk_i   (rd_clk_i),
        .src_rst_n_i (rd_rst_n_i),
        .src_ptr_i   (rd_ptr_q),
        .dst_clk_i   (wr_clk_i),
        .dst_rst_n_i (wr_rst_n_i),
        .dst_ptr_o   (rd_ptr_wr)
    );

endmodule

// File: logic/fifo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-clock fifo package: word width, depth and the
// vector types shared by the control, sync and memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fifo_pkg;

    // size of one stored word.
    localparam int FIFO_WIDTH = 8;

    // number of words, must stay a power of two.
    localparam int FIFO_DEPTH = 8;

    localparam int ADDR_W = $clog2(FIFO_DEPTH); // ram index width.

    // the extra msb is the wrap bit that tells full from empty.
    localparam int PTR_W = ADDR_W + 1;

    // one fifo word.
    typedef logic [FIFO_WIDTH-1:0] data_t;

    // ram index.
    typedef logic [ADDR_W-1:0] addr_t;

    // binary or gray pointer including the wrap bit.
    typedef logic [PTR_W-1:0] ptr_t;

    // count from 0 up to FIFO_DEPTH, used for free and available words.
    typedef logic [PTR_W-1:0] level_t;

endpackage

// File: logic/ptr_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pointer crossing: gray register at the source, two
// flops at the destination, then back to binary.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ptr_sync import fifo_pkg::*; (
    input  logic src_clk_i,
    input  logic src_rst_n_i,
    input  ptr_t src_ptr_i,

    input  logic dst_clk_i,
    input  logic dst_rst_n_i,
    output ptr_t dst_ptr_o
);

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // each binary bit is the xor of all gray bits at and above it.
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    ptr_t src_gray_q;
    ptr_t dst_meta_q;
    ptr_t dst_sync_q;

    // registered so the crossing bus never carries combinational glitches,
    // and only one bit changes per source edge.
    always_ff @(posedge src_clk_i or negedge src_rst_n_i) begin
        if (!src_rst_n_i) begin
            src_gray_q <= '0;
        end else begin
            src_gray_q <= bin2gray(src_ptr_i);
        end
    end

    // first flop may go metastable, the second gives it a cycle to settle.
    always_ff @(posedge dst_clk_i or negedge dst_rst_n_i) begin
        if (!dst_rst_n_i) begin
            dst_meta_q <= '0;
            dst_sync_q <= '0;
        end else begin
            dst_meta_q <= src_gray_q;
            dst_sync_q <= dst_meta_q;
        end
    end

    assign dst_ptr_o = gray2bin(dst_sync_q);

endmodule

// File: logic/ram_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ram port bundle between fifo control and storage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface ram_if import fifo_pkg::*; ();

    // write port, in the write clock domain.
    logic  wr_en;
    addr_t wr_addr;
    data_t wr_data;

    // read port, in the read clock domain.
    logic  rd_en;
    addr_t rd_addr;
    data_t rd_data; // registered inside the ram.

    modport ctrl (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: logic/ram_tp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-port ram, one clock per port, registered read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ram_tp import fifo_pkg::*; (
    input logic wr_clk_i,
    input logic rd_clk_i,

    ram_if.mem ram
);

    data_t mem_q [FIFO_DEPTH];
    data_t rd_data_q;

    // the write lands at the same edge where it is enabled.
    always_ff @(posedge wr_clk_i) begin
        if (ram.wr_en) begin
            mem_q[ram.wr_addr] <= ram.wr_data;
        end
    end

    // output register only moves on an enabled read, so it holds
    // the last word read in between.
    always_ff @(posedge rd_clk_i) begin
        if (ram.rd_en) begin
            rd_data_q <= mem_q[ram.rd_addr];
        end
    end

    assign ram.rd_data = rd_data_q;

endmodule
